// File: Bender.yml
package:
  name: cpu16

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - cpu_stage_if.sv
      - reg_file.sv
      - fetch_unit.sv
      - decode_unit.sv
      - hazard_unit.sv
      - execute_unit.sv
      - mem_writeback.sv
      - cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_sva.sv
      - cpu_tb.sv

// File: compile.f
+incdir+.
cpu_pkg.sv
cpu_stage_if.sv
reg_file.sv
fetch_unit.sv
decode_unit.sv
hazard_unit.sv
execute_unit.sv
mem_writeback.sv
cpu.sv
cpu_sva.sv
cpu_tb.sv

// File: cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  output logic [`DATA_WIDTH-1:0] pc,
  input  logic [`DATA_WIDTH-1:0] imemData,
  output logic [`DATA_WIDTH-1:0] dmemAddr,
  output logic [`DATA_WIDTH-1:0] dmemWrData,
  output logic                   dmemWe,
  output logic                   dmemRe,
  input  logic [`DATA_WIDTH-1:0] dmemRdData,
  output logic                   hlt
);

  logic [`DATA_WIDTH-1:0]     ifInstr;       // IF/ID
  logic [`DATA_WIDTH-1:0]     ifPcInc;
  logic                       stall;
  logic                       branchTaken;
  logic [`DATA_WIDTH-1:0]     branchTarget;
  logic                       haltInDecode;
  logic [`REG_ADDR_WIDTH-1:0] idRsAddr;
  logic [`REG_ADDR_WIDTH-1:0] idRtAddr;
  idEx_t                      idEx;
  fwdSel_t                    forwardA;
  fwdSel_t                    forwardB;
  logic [`DATA_WIDTH-1:0]     memFwdData;
  wbBus_t                     wb;            // MEM/WB

  memStageIf memStage ();  // EX/MEM

  fetchUnit fetch (
    .clk (clk), .rst (rst), .stall (stall), .branchTaken (branchTaken),
    .haltInDecode (haltInDecode), .branchTarget (branchTarget),
    .imemData (imemData), .pc (pc), .instr (ifInstr), .pcInc (ifPcInc)
  );

  decodeUnit decode (
    .clk (clk), .rst (rst), .instr (ifInstr), .pcInc (ifPcInc), .stall (stall),
    .branchTaken (branchTaken), .wb (wb), .idEx (idEx),
    .haltInDecode (haltInDecode), .rsAddr (idRsAddr), .rtAddr (idRtAddr)
  );

  hazardUnit hazard (
    .idRsAddr (idRsAddr), .idRtAddr (idRtAddr), .idEx (idEx), .memStage (memStage),
    .wb (wb), .stall (stall), .forwardA (forwardA), .forwardB (forwardB)
  );

  executeUnit execute (
    .clk (clk), .rst (rst), .idEx (idEx), .forwardA (forwardA), .forwardB (forwardB),
    .memFwdData (memFwdData), .wb (wb), .memStage (memStage),
    .branchTaken (branchTaken), .branchTarget (branchTarget)
  );

  memWriteback memWb (
    .clk (clk), .rst (rst), .memStage (memStage), .dmemRdData (dmemRdData),
    .dmemAddr (dmemAddr), .dmemWrData (dmemWrData), .dmemWe (dmemWe),
    .dmemRe (dmemRe), .memFwdData (memFwdData), .wb (wb), .hlt (hlt)
  );

endmodule

// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////

// Word width and the address width of both memories
`define DATA_WIDTH 16

// Register file
`define REG_ADDR_WIDTH 4   // rd, rs, rt fields
`define NUM_REGS 16        // R0 hardwired to zero

// Instruction fields
`define OPCODE_WIDTH 4     // Bits [15:12]

`endif

// File: cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

  ////////////////////////////////////////
  // ISA encodings
  ////////////////////////////////////////

  typedef enum logic [`OPCODE_WIDTH-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_NOR  = 4'd3,
    OP_ADDI = 4'd4,
    OP_LW   = 4'd8,
    OP_SW   = 4'd9,
    OP_BEQZ = 4'd12,
    OP_HLT  = 4'd15
  } opcode_t;  // Anything else decodes as a no-op

  // Order matches the low opcode bits of the R-type group
  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_NOR} aluOp_t;

  // ADD R0,R0,R0 doubles as the pipeline bubble
  localparam logic [`DATA_WIDTH-1:0] INSTR_BUBBLE = '0;

  ////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////

  typedef struct packed {
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   useImm;   // Operand B from imm4
    logic   branch;   // BEQZ
    logic   halt;
    aluOp_t aluOp;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                      ctrl;
    logic [`DATA_WIDTH-1:0]     pcInc;
    logic [`DATA_WIDTH-1:0]     rsData;
    logic [`DATA_WIDTH-1:0]     rdtData;       // rt operand, or rd for SW and BEQZ
    logic [`DATA_WIDTH-1:0]     imm;
    logic [`DATA_WIDTH-1:0]     branchOffset;
    logic [`REG_ADDR_WIDTH-1:0] rsAddr;        // Forwarding compares
    logic [`REG_ADDR_WIDTH-1:0] rtAddr;
    logic [`REG_ADDR_WIDTH-1:0] dstAddr;
  } idEx_t;

  typedef struct packed {
    logic                       regWrite;
    logic [`REG_ADDR_WIDTH-1:0] dstAddr;
    logic [`DATA_WIDTH-1:0]     data;
  } wbBus_t;

  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwdSel_t;

endpackage

// File: cpu_stage_if.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

// EX/MEM stage register shared by execute, memory and hazard logic
interface memStageIf import cpu_pkg::*; ();

  logic                       valid;      // Real instruction, not a flushed slot
  ctrl_t                      ctrl;
  logic [`DATA_WIDTH-1:0]     aluResult;  // Also the data address
  logic [`DATA_WIDTH-1:0]     storeData;  // Forwarded rd for SW
  logic [`REG_ADDR_WIDTH-1:0] dstAddr;
  logic [`DATA_WIDTH-1:0]     pcInc;

  // Register owner
  modport exec (output valid, ctrl, aluResult, storeData, dstAddr, pcInc);

  // Memory access and writeback select
  modport mem (input valid, ctrl, aluResult, storeData, dstAddr, pcInc);

  // Forward-select compare only
  modport hazard (input valid, ctrl, dstAddr);

endinterface

// File: cpu_sva.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuSva (
  input logic                   clk,
  input logic                   rst,
  input logic [`DATA_WIDTH-1:0] pc,
  input logic                   dmemWe,
  input logic                   dmemRe,
  input logic                   hlt
);

  int failCount = 0;  // Failed attempts so far

  // One data access per cycle
  noDualAccess: assert property (@(posedge clk) disable iff (rst) !(dmemWe && dmemRe))
    else begin
      failCount++;
      $error("dmemWe and dmemRe high in the same cycle");
    end

  // Sticky halt
  haltSticky: assert property (@(posedge clk) $fell(hlt) |-> $past(rst))
    else begin
      failCount++;
      $error("hlt fell without a reset");
    end

  haltHoldsPc: assert property (@(posedge clk) disable iff (rst) hlt |=> $stable(pc))
    else begin
      failCount++;
      $error("pc moved while halted");
    end

  resetQuiet: assert property (@(posedge clk) rst |=> !dmemWe)
    else begin
      failCount++;
      $error("dmemWe high in the cycle after reset");
    end

endmodule

bind cpu cpuSva checks (
  .clk (clk), .rst (rst), .pc (pc), .dmemWe (dmemWe), .dmemRe (dmemRe), .hlt (hlt)
);

// File: cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuTb;

  localparam int MAX_CYCLES = 2000;  // Five programs under 200 cycles each plus margin

  logic                   clk = 1'b0;
  logic                   rst = 1'b1;
  logic                   dmemWe;
  logic                   dmemRe;
  logic                   hlt;
  logic [`DATA_WIDTH-1:0] pc;
  logic [`DATA_WIDTH-1:0] imemData;
  logic [`DATA_WIDTH-1:0] dmemAddr;
  logic [`DATA_WIDTH-1:0] dmemWrData;
  logic [`DATA_WIDTH-1:0] dmemRdData;

  logic [`DATA_WIDTH-1:0] imem [256];
  logic [`DATA_WIDTH-1:0] dmem [256];
  logic [`DATA_WIDTH-1:0] initMem [256];   // Data image restored on every reset
  logic [`DATA_WIDTH-1:0] prog [$];
  logic [`DATA_WIDTH-1:0] logAddr [$];     // Stores seen at the data port
  logic [`DATA_WIDTH-1:0] logData [$];
  logic [`DATA_WIDTH-1:0] expAddr [$];     // Stores predicted from the ISA
  logic [`DATA_WIDTH-1:0] expData [$];
  logic [`DATA_WIDTH-1:0] loadAddr [$];    // Loads seen at the data port
  logic [`DATA_WIDTH-1:0] expLoad [$];     // Loads predicted from the ISA
  logic [31:0]            lcgState = 32'd88735;
  int                     cycleCount = 0;

  cpu UUT (
    .clk (clk), .rst (rst), .pc (pc), .imemData (imemData), .dmemAddr (dmemAddr),
    .dmemWrData (dmemWrData), .dmemWe (dmemWe), .dmemRe (dmemRe),
    .dmemRdData (dmemRdData), .hlt (hlt)
  );

  assign imemData   = imem[pc[7:0]];        // Same-cycle fetch
  assign dmemRdData = dmem[dmemAddr[7:0]];  // Same-cycle load

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Data memory and store log
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      dmem <= initMem;  // Fresh image per program
      logAddr.delete();
      logData.delete();
      loadAddr.delete();
    end else begin
      if (dmemWe) begin
        dmem[dmemAddr[7:0]] <= dmemWrData;
        logAddr.push_back(dmemAddr);
        logData.push_back(dmemWrData);
      end
      if (dmemRe) loadAddr.push_back(dmemAddr);  // Every load strobe
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= MAX_CYCLES) begin
      $display("Timeout: the CPU did not finish its programs within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $fatal(1, "run aborted on cycle limit");
    end
  end

  // Bound assertions count their failures
  always @(posedge clk) begin
    if (UUT.checks.failCount != 0) begin
      $display("An assertion in cpuSva failed");
      $display("TB FAILED");
      $fatal(1, "assertion failure");
    end
  end

  function automatic logic [15:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[30:15];  // Upper bits, better spread
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stepCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;  // Drive and sample clear of the edge
    end
  endtask

  task automatic expectStore(input logic [15:0] addr, input logic [15:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic expectLoad(input logic [15:0] addr);
    expLoad.push_back(addr);
  endtask

  // Reset with the program in place and bubbles past its end
  task automatic startProgram();
    rst = 1'b1;
    expAddr.delete();
    expData.delete();
    expLoad.delete();
    foreach (imem[i]) begin
      imem[i] = (i < prog.size()) ? prog[i] : '0;
    end
    stepCycles(2);
    rst = 1'b0;
  endtask

  task automatic finishProgram();
    while (hlt !== 1'b1) begin
      stepCycles(1);
    end
    checkValue("storeCount", logAddr.size(), expAddr.size());
    foreach (expAddr[i]) begin
      checkValue("dmemAddr", logAddr[i], expAddr[i]);
      checkValue("dmemWrData", logData[i], expData[i]);
    end
    checkValue("loadCount", loadAddr.size(), expLoad.size());
    foreach (expLoad[i]) begin
      checkValue("dmemAddr on load", loadAddr[i], expLoad[i]);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic aluChainTest();
    logic [15:0] a, b, r3, r4, r5, r6;
    a  = initMem[1];
    b  = initMem[2];
    r3 = a + b;
    r4 = r3 - a;
    r5 = r4 & r3;
    r6 = ~(r5 | b);
    // LW R1,1(R0)  LW R2,2(R0)  ADD R3,R1,R2  SUB R4,R3,R1  AND R5,R4,R3  NOR R6,R5,R2
    // ADDI R7,R6,-3  SW R7,7(R0)  SW R3..R6 at 3..6  HLT
    prog = '{16'h8101, 16'h8202, 16'h0312, 16'h1431, 16'h2543, 16'h3652,
             16'h476D, 16'h9707, 16'h9303, 16'h9404, 16'h9505, 16'h9606, 16'hF000};
    startProgram();
    expectLoad(16'd1);
    expectLoad(16'd2);
    expectStore(16'd7, r6 + 16'hFFFD);  // Store data forwarded from MEM
    expectStore(16'd3, r3);
    expectStore(16'd4, r4);
    expectStore(16'd5, r5);
    expectStore(16'd6, r6);
    finishProgram();
  endtask

  task automatic loadUseTest();
    // ADDI R2,R0,5  LW R1,4(R0)  ADD R3,R1,R2  SW R3,2(R0)  LW R4,6(R0)  SW R4,1(R0)  HLT
    prog = '{16'h4205, 16'h8104, 16'h0312, 16'h9302, 16'h8406, 16'h9401, 16'hF000};
    startProgram();
    expectLoad(16'd4);
    expectLoad(16'd6);
    expectStore(16'd2, initMem[4] + 16'd5);
    expectStore(16'd1, initMem[6]);  // Load feeding store data
    finishProgram();
  endtask

  task automatic branchTest();
    // ADDI R1,R0,1  BEQZ R0,+3  SW R1 at 1..3 skipped  SW R1,4(R0)  BEQZ R1,+2 not taken
    // SW R1,5(R0)  ADDI R2,R1,-1  BEQZ R2,+1  SW R1,6(R0) skipped  SW R2,7(R0)  HLT
    prog = '{16'h4101, 16'hC003, 16'h9101, 16'h9102, 16'h9103, 16'h9104, 16'hC102,
             16'h9105, 16'h421F, 16'hC201, 16'h9106, 16'h9207, 16'hF000};
    startProgram();
    expectStore(16'd4, 16'd1);
    expectStore(16'd5, 16'd1);
    expectStore(16'd7, 16'd0);
    finishProgram();
  endtask

  task automatic haltR0Test();
    logic [15:0] holdPc;
    // ADDI R1,R0,6  ADDI R0,R1,3  SW R0,1(R0)  ADD R0,R1,R1  SW R0,2(R0)  SW R1,3(R0)  HLT
    // Two SWs after the HLT
    prog = '{16'h4106, 16'h4013, 16'h9001, 16'h0011, 16'h9002, 16'h9103, 16'hF000,
             16'h9104, 16'h9105};
    startProgram();
    expectStore(16'd1, 16'd0);  // R0 stays zero
    expectStore(16'd2, 16'd0);
    expectStore(16'd3, 16'd6);
    finishProgram();
    holdPc = pc;
    repeat (20) begin
      stepCycles(1);
      checkValue("pc", pc, holdPc);
      checkValue("hlt", hlt, 1);
    end
    checkValue("storeCount", logAddr.size(), 3);
  endtask

  task automatic midResetTest();
    logic [15:0] acc;
    int          k;
    // ADDI R1,R0,5  ADD R2,R0,R0  loop: ADD R2,R2,R1  SW R2,0(R1)  ADDI R1,R1,-1
    // BEQZ R1,+1 exits  BEQZ R0,-5 back to loop  HLT
    prog = '{16'h4105, 16'h0200, 16'h0221, 16'h9210, 16'h411F, 16'hC101, 16'hC0FB, 16'hF000};
    startProgram();
    stepCycles(15);
    checkValue("hlt", hlt, 0);  // Loop still running
    rst = 1'b1;
    stepCycles(2);
    checkValue("hlt", hlt, 0);
    checkValue("dmemWe", dmemWe, 0);
    checkValue("pc", pc, 0);
    acc = '0;
    for (k = 5; k > 0; k--) begin
      acc = acc + 16'(k);
      expectStore(16'(k), acc);  // Running sum at address R1
    end
    rst = 1'b0;
    finishProgram();
  endtask

  initial begin
    foreach (initMem[i]) begin
      initMem[i] = lcgNext();
    end
    foreach (imem[i]) begin
      imem[i] = '0;
    end
    stepCycles(1);
    aluChainTest();
    loadUseTest();
    branchTest();
    haltR0Test();
    midResetTest();
    if (UUT.checks.failCount == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Assertion failures in cpuSva: %0d", UUT.checks.failCount);
      $display("TB FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// File: decode_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decodeUnit import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`DATA_WIDTH-1:0]     instr,
  input  logic [`DATA_WIDTH-1:0]     pcInc,
  input  logic                       stall,
  input  logic                       branchTaken,
  input  wbBus_t                     wb,
  output idEx_t                      idEx,
  output logic                       haltInDecode,
  output logic [`REG_ADDR_WIDTH-1:0] rsAddr,
  output logic [`REG_ADDR_WIDTH-1:0] rtAddr
);

  opcode_t                opcode;
  ctrl_t                  ctrl;
  logic                   useRs;    // Instruction really reads rs
  logic                   useRt;    // Reads the second port
  logic                   rdAsSrc;  // SW and BEQZ read rd on port B
  logic [`DATA_WIDTH-1:0] rsData;
  logic [`DATA_WIDTH-1:0] rdtData;

  assign opcode = opcode_t'(instr[15:12]);

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////

  always_comb begin
    ctrl    = '0;
    useRs   = 1'b0;
    useRt   = 1'b0;
    rdAsSrc = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluOp_t'(instr[13:12]);  // Opcode LSBs select the function
        useRs         = 1'b1;
        useRt         = 1'b1;
      end
      OP_ADDI, OP_LW: begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = (opcode == OP_LW);
        ctrl.useImm   = 1'b1;  // rs + imm4
        useRs         = 1'b1;
      end
      OP_SW: begin
        ctrl.memWrite = 1'b1;
        ctrl.useImm   = 1'b1;
        useRs         = 1'b1;
        useRt         = 1'b1;
        rdAsSrc       = 1'b1;  // Store data from rd
      end
      OP_BEQZ: begin
        ctrl.branch = 1'b1;
        useRt       = 1'b1;
        rdAsSrc     = 1'b1;   // Tested register
      end
      OP_HLT:  ctrl.halt = 1'b1;
      default: ctrl = '0;     // Unused opcodes fall through as no-ops
    endcase
  end

  // Unused sources read R0 so they never match a hazard
  assign rsAddr       = useRs ? instr[7:4] : '0;
  assign rtAddr       = !useRt ? '0 : (rdAsSrc ? instr[11:8] : instr[3:0]);
  assign haltInDecode = ctrl.halt;

  regFile regs (
    .clk       (clk),
    .rst       (rst),
    .readAddrA (rsAddr),
    .readAddrB (rtAddr),
    .readDataA (rsData),
    .readDataB (rdtData),
    .wb        (wb)
  );

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || stall || branchTaken) begin
      idEx <= '0;  // Bubble
    end else begin
      idEx.ctrl         <= ctrl;
      idEx.pcInc        <= pcInc;
      idEx.rsData       <= rsData;
      idEx.rdtData      <= rdtData;
      idEx.imm          <= {{(`DATA_WIDTH-4){instr[3]}}, instr[3:0]};
      idEx.branchOffset <= {{(`DATA_WIDTH-8){instr[7]}}, instr[7:0]};
      idEx.rsAddr       <= rsAddr;
      idEx.rtAddr       <= rtAddr;
      idEx.dstAddr      <= instr[11:8];
    end
  end

endmodule

// File: execute_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module executeUnit import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  idEx_t                  idEx,
  input  fwdSel_t                forwardA,
  input  fwdSel_t                forwardB,
  input  logic [`DATA_WIDTH-1:0] memFwdData,
  input  wbBus_t                 wb,
  memStageIf.exec                memStage,
  output logic                   branchTaken,
  output logic [`DATA_WIDTH-1:0] branchTarget
);

  logic [`DATA_WIDTH-1:0] opA;
  logic [`DATA_WIDTH-1:0] rdtVal;     // Forwarded second register
  logic [`DATA_WIDTH-1:0] opB;
  logic [`DATA_WIDTH-1:0] aluResult;

  function automatic logic [`DATA_WIDTH-1:0] fwdMux(input fwdSel_t sel,
                                                   input logic [`DATA_WIDTH-1:0] regVal);
    case (sel)
      FWD_MEM: return memFwdData;  // Producer one ahead
      FWD_WB:  return wb.data;     // Producer two ahead
      default: return regVal;
    endcase
  endfunction

  ////////////////////////////////////////
  // Operands and ALU
  ////////////////////////////////////////

  assign opA    = fwdMux(forwardA, idEx.rsData);
  assign rdtVal = fwdMux(forwardB, idEx.rdtData);
  assign opB    = idEx.ctrl.useImm ? idEx.imm : rdtVal;  // ADDI, LW, SW

  always_comb begin
    case (idEx.ctrl.aluOp)
      ALU_ADD: aluResult = opA + opB;  // Also address calc
      ALU_SUB: aluResult = opA - opB;
      ALU_AND: aluResult = opA & opB;
      default: aluResult = ~(opA | opB);
    endcase
  end

  // BEQZ tests rd after forwarding
  assign branchTaken  = idEx.ctrl.branch && (rdtVal == '0);
  assign branchTarget = idEx.pcInc + idEx.branchOffset;

  ////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      memStage.valid <= 1'b0;
      memStage.ctrl  <= '0;
    end else begin
      memStage.valid <= |idEx.ctrl;  // Bubbles and no-ops carry no control
      memStage.ctrl  <= idEx.ctrl;
    end
  end

  always_ff @(posedge clk) begin
    memStage.aluResult <= aluResult;
    memStage.storeData <= rdtVal;       // Store data after forwarding
    memStage.dstAddr   <= idEx.dstAddr;
    memStage.pcInc     <= idEx.pcInc;
  end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetchUnit import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   branchTaken,
  input  logic                   haltInDecode,
  input  logic [`DATA_WIDTH-1:0] branchTarget,
  input  logic [`DATA_WIDTH-1:0] imemData,
  output logic [`DATA_WIDTH-1:0] pc,
  output logic [`DATA_WIDTH-1:0] instr,
  output logic [`DATA_WIDTH-1:0] pcInc
);

  logic                   halted;   // Sticky until reset
  logic                   haltNow;  // Includes HLT sitting in ID this cycle
  logic [`DATA_WIDTH-1:0] pcPlus;

  assign pcPlus  = pc + 1'b1;
  assign haltNow = halted | (haltInDecode & ~branchTaken);

  // Branch wins over a hold, a hold over the sequential PC
  always_ff @(posedge clk) begin
    if (rst) pc <= '0;
    else if (branchTaken) pc <= branchTarget;
    else if (!(stall || haltNow)) pc <= pcPlus;
  end

  always_ff @(posedge clk) begin
    if (rst) halted <= 1'b0;
    else if (haltInDecode && !branchTaken) halted <= 1'b1;  // A flushed HLT never counts
  end

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) instr <= INSTR_BUBBLE;
    else if (branchTaken) instr <= INSTR_BUBBLE;  // Cancel wrong-path fetch
    else if (stall) instr <= instr;               // Load-use hold
    else if (haltNow) instr <= INSTR_BUBBLE;
    else instr <= imemData;
  end

  always_ff @(posedge clk) begin
    if (!stall) pcInc <= pcPlus;  // Return point for BEQZ offset
  end

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module hazardUnit import cpu_pkg::*; (
  input  logic [`REG_ADDR_WIDTH-1:0] idRsAddr,
  input  logic [`REG_ADDR_WIDTH-1:0] idRtAddr,
  input  idEx_t                      idEx,
  memStageIf.hazard                  memStage,
  input  wbBus_t                     wb,
  output logic                       stall,
  output fwdSel_t                    forwardA,
  output fwdSel_t                    forwardB
);

  ////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////

  // Youngest producer wins, R0 never forwards
  function automatic fwdSel_t pickSource(input logic [`REG_ADDR_WIDTH-1:0] src);
    logic memHit;
    logic wbHit;
    memHit = memStage.valid && memStage.ctrl.regWrite &&
             (memStage.dstAddr != '0) && (memStage.dstAddr == src);
    wbHit  = wb.regWrite && (wb.dstAddr != '0) && (wb.dstAddr == src);
    if (memHit) return FWD_MEM;
    else if (wbHit) return FWD_WB;
    else return FWD_NONE;
  endfunction

  assign forwardA = pickSource(idEx.rsAddr);
  assign forwardB = pickSource(idEx.rtAddr);

  ////////////////////////////////////////
  // Load-use
  ////////////////////////////////////////

  // Load data only exists in MEM, so the consumer waits one slot
  assign stall = idEx.ctrl.memRead && (idEx.dstAddr != '0) &&
                 ((idEx.dstAddr == idRsAddr) || (idEx.dstAddr == idRtAddr));

endmodule

// File: mem_writeback.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memWriteback import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  memStageIf.mem                 memStage,
  input  logic [`DATA_WIDTH-1:0] dmemRdData,
  output logic [`DATA_WIDTH-1:0] dmemAddr,
  output logic [`DATA_WIDTH-1:0] dmemWrData,
  output logic                   dmemWe,
  output logic                   dmemRe,
  output logic [`DATA_WIDTH-1:0] memFwdData,
  output wbBus_t                 wb,
  output logic                   hlt
);

  // Data port answered in the same cycle
  assign dmemAddr   = memStage.aluResult;
  assign dmemWrData = memStage.storeData;
  assign dmemWe     = memStage.valid && memStage.ctrl.memWrite;
  assign dmemRe     = memStage.valid && memStage.ctrl.memRead;

  // Writeback value doubles as the MEM-stage forward
  assign memFwdData = memStage.ctrl.memRead ? dmemRdData : memStage.aluResult;

  ////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wb <= '0;
    end else begin
      wb.regWrite <= memStage.valid && memStage.ctrl.regWrite;
      wb.dstAddr  <= memStage.dstAddr;
      wb.data     <= memFwdData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) hlt <= 1'b0;
    else if (memStage.valid && memStage.ctrl.halt) hlt <= 1'b1;  // Sticky
  end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regFile import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
  output logic [`DATA_WIDTH-1:0]     readDataA,
  output logic [`DATA_WIDTH-1:0]     readDataB,
  input  wbBus_t                     wb
);

  logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];
  logic                   wbLive;  // Writeback that lands this edge

  assign wbLive = wb.regWrite && (wb.dstAddr != '0);

  always_ff @(posedge clk) begin
    if (!rst && wbLive) regs[wb.dstAddr] <= wb.data;  // R0 never written
  end

  // Write-through so WB and ID overlap in one cycle
  assign readDataA = (readAddrA == '0) ? '0 :
                     (wbLive && wb.dstAddr == readAddrA) ? wb.data : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 :
                     (wbLive && wb.dstAddr == readAddrB) ? wb.data : regs[readAddrB];

endmodule
